//--- dv/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// raster flags from the small test timing, positive sync
function automatic vid_flags_t exp_flags(input int h, input int v);
    vid_flags_t f;
    f.hsync  = (h >= H_SYNC_START) && (h < H_SYNC_START + H_SYNC_LEN);
    f.vsync  = (v >= V_SYNC_START) && (v < V_SYNC_START + V_SYNC_LEN);
    f.active = (h < H_ACTIVE) && (v < V_ACTIVE);
    return f;
endfunction

// control symbol for {c1, c0}
function automatic tmds_word_t ctrl_code(input logic [1:0] c);
    case (c)
        2'b00:   return TMDS_CTRL_00;
        2'b01:   return TMDS_CTRL_01;
        2'b10:   return TMDS_CTRL_10;
        default: return TMDS_CTRL_11;
    endcase
endfunction

// plain dvi data decode, bit 9 undoes the inversion, bit 8 picks xor or xnor
function automatic logic [7:0] decode_tmds(input tmds_word_t w);
    logic [7:0] q;
    logic [7:0] d;
    q    = w[9] ? ~w[7:0] : w[7:0];
    d[0] = q[0];
    for (int i = 1; i < 8; i++) begin
        d[i] = w[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
    end
    return d;
endfunction

function automatic rgb888_t decode_rgb(input tmds_bus_t b);
    rgb888_t c;
    c.red   = decode_tmds(b.red);
    c.green = decode_tmds(b.green);
    c.blue  = decode_tmds(b.blue);
    return c;
endfunction

// source pixel under a display position, scaled up to 8 bits per channel
function automatic rgb888_t exp_pixel(input int h, input int v);
    int      sc;
    int      sr;
    rgb565_t p;
    rgb888_t c;
    sc = h >> ZOOM_SHIFT;
    sr = v >> ZOOM_SHIFT;
    if (sc >= SRC_W || sr >= SRC_H) begin
        return '0; // outside the source shows black
    end
    p       = disp_img[sr * SRC_W + sc];
    c.red   = 8'(p.red) << 3;
    c.green = 8'(p.green) << 2;
    c.blue  = 8'(p.blue) << 3;
    return c;
endfunction

`endif

//--- dv/tb_hdmi_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_hdmi_top import video_pkg::*; ();

    // small raster with a 10x6 source zoomed 4x
    localparam int SRC_W        = 10;
    localparam int SRC_H        = 6;
    localparam int ZOOM_SHIFT   = 2;
    localparam int H_ACTIVE     = 32;
    localparam int H_TOTAL      = 40;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_LEN   = 4;
    localparam int V_ACTIVE     = 20;
    localparam int V_TOTAL      = 26;
    localparam int V_SYNC_START = 21;
    localparam int V_SYNC_LEN   = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL; // 1040
    localparam int LATENCY      = 4;  // counters to tmds word
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 2;
    localparam int ACK_LIMIT    = 16; // handshake timeout per phase
    localparam int REQ_HOLD     = 2;  // extra cycles the source keeps req up after ack
    localparam int N_OOR        = 4;  // out of range writes per batch
    localparam int N_REWRITE    = 8;
    localparam int N_WRITES     = SRC_W * SRC_H + 2 * N_OOR + N_REWRITE;
    localparam int HS_CYCLES    = 3 + REQ_HOLD; // one four-phase write with the slow release
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + LATENCY + 3 * FRAME_CYCLES
                                   + N_WRITES * HS_CYCLES + 200;

    logic      clk_pixel;
    logic      arst_n = 1'b0;
    logic      wr_req = 1'b0;
    pix_wr_t   wr     = '0;
    logic      wr_ack;
    tmds_bus_t tmds;
    logic      frame_start;

    rgb565_t shadow   [SRC_W * SRC_H]; // what the source has written
    rgb565_t disp_img [SRC_W * SRC_H]; // shadow as it stood at frame start
    int      pix_errs  = 0;
    int      ctrl_errs = 0;
    int      ack_errs  = 0;
    int      fs_errs   = 0;

    `include "tb_ref.svh"

    hdmi_top #(
        .SRC_W(SRC_W), .SRC_H(SRC_H), .ZOOM_SHIFT(ZOOM_SHIFT),
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) DUT (
        .clk_pixel(clk_pixel), .arst_n(arst_n),
        .wr_req(wr_req), .wr(wr), .wr_ack(wr_ack),
        .tmds(tmds), .frame_start(frame_start)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;
    end

    task automatic check_pixel(input rgb888_t got, input rgb888_t want, input string where);
        if (got !== want) begin
            $display("FAIL %0t: pixel %s got %h expected %h", $time, where, got, want);
            pix_errs++;
        end
    endtask

    task automatic check_ctrl(input tmds_word_t got, input tmds_word_t want,
                              input string where);
        if (got !== want) begin
            $display("FAIL %0t: symbol %s got %b expected %b", $time, where, got, want);
            ctrl_errs++;
        end
    endtask

    task automatic check_frame_start(input logic got, input logic want, input int pos);
        if (got !== want) begin
            $display("FAIL %0t: frame_start %b at scan position %0d", $time, got, pos);
            fs_errs++;
        end
    endtask

    // waits for wr_ack to reach a level within the expected number of cycles
    task automatic check_ack(input logic want, input int cycles, input string phase);
        int n;
        n = 0;
        while (wr_ack !== want && n < ACK_LIMIT) begin
            @(negedge clk_pixel);
            n++;
        end
        if (wr_ack !== want) begin
            $display("handshake timeout at %0t: wr_ack never went to %0b in %s",
                     $time, want, phase);
            ack_errs++;
        end else if (n != cycles) begin
            $display("FAIL %0t: %s took %0d cycles, expected %0d", $time, phase, n, cycles);
            ack_errs++;
        end
    endtask

    function automatic rgb565_t random_pixel();
        return rgb565_t'(16'($urandom()));
    endfunction

    // full four-phase write started on a falling edge
    task automatic write_pixel(input int col, input int row, input rgb565_t p);
        wr.col   = 9'(col);
        wr.row   = 8'(row);
        wr.pixel = p;
        wr_req   = 1'b1;
        check_ack(1'b1, 2, "ack rise"); // wr held until ack seen
        repeat (REQ_HOLD) begin // ack must stay up while a slow source holds req
            @(negedge clk_pixel);
            check_ack(1'b1, 0, "ack hold");
        end
        wr_req = 1'b0;
        check_ack(1'b0, 1, "ack fall");
        if (col < SRC_W && row < SRC_H) begin
            shadow[row * SRC_W + col] = p; // only in range writes land
        end
    endtask

    // alternate between columns and rows past the source edge
    task automatic write_out_of_range(input int n);
        for (int i = 0; i < n; i++) begin
            if (i % 2 == 0) begin
                write_pixel(SRC_W + i, int'($urandom_range(SRC_H - 1, 0)), random_pixel());
            end else begin
                write_pixel(int'($urandom_range(SRC_W - 1, 0)), SRC_H + i, random_pixel());
            end
        end
    endtask

    task automatic wait_frame_start();
        do begin
            @(negedge clk_pixel);
        end while (frame_start !== 1'b1);
    endtask

    // stimulus
    initial begin
        void'($urandom(32'h0f9feba7));
        arst_n = 1'b0;
        wr_req = 1'b0;
        wr     = '0;
        repeat (RESET_CYCLES) @(negedge clk_pixel);
        check_ack(1'b0, 0, "reset");
        arst_n = 1'b1;
        for (int r = 0; r < SRC_H; r++) begin // frame 0 fills the buffer
            for (int c = 0; c < SRC_W; c++) begin
                write_pixel(c, r, random_pixel());
            end
        end
        write_out_of_range(N_OOR);
        wait_frame_start();                   // frame 1 is checked in full
        repeat (V_ACTIVE * H_TOTAL) @(negedge clk_pixel); // into vertical blanking
        for (int i = 0; i < N_REWRITE; i++) begin
            write_pixel(int'($urandom_range((H_ACTIVE >> ZOOM_SHIFT) - 1, 0)),
                        int'($urandom_range((V_ACTIVE >> ZOOM_SHIFT) - 1, 0)),
                        random_pixel());
        end
        write_out_of_range(N_OOR);
        wait_frame_start();                   // frame 2 shows the rewrites
        wait_frame_start();                   // frame 2 done
        @(posedge clk_pixel);
        $display("errors: pixel %0d, control %0d, handshake %0d, frame_start %0d",
                 pix_errs, ctrl_errs, ack_errs, fs_errs);
        if (pix_errs + ctrl_errs + ack_errs + fs_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // compare one tmds word per falling edge
    initial begin : compare
        int         k;
        int         pos;
        int         frame_idx;
        int         h;
        int         v;
        vid_flags_t f;
        k = 0;
        wait (arst_n);
        forever begin
            @(negedge clk_pixel);
            k++; // rising edges since reset release
            if (k < LATENCY) begin
                check_ctrl(tmds.red, '0, "red before fill");
                check_ctrl(tmds.green, '0, "green before fill");
                check_ctrl(tmds.blue, '0, "blue before fill");
                check_frame_start(frame_start, 1'b0, -1);
            end else begin
                pos       = (k - LATENCY) % FRAME_CYCLES;
                frame_idx = (k - LATENCY) / FRAME_CYCLES;
                h         = pos % H_TOTAL;
                v         = pos / H_TOTAL;
                if (pos == 0) begin
                    disp_img = shadow;
                end
                check_frame_start(frame_start, pos == 0, pos);
                f = exp_flags(h, v);
                if (f.active) begin
                    if (frame_idx > 0) begin // frame 0 is scanned while filling
                        check_pixel(decode_rgb(tmds), exp_pixel(h, v),
                                    $sformatf("(%0d,%0d)", h, v));
                    end
                end else begin
                    check_ctrl(tmds.red, TMDS_CTRL_00, $sformatf("red (%0d,%0d)", h, v));
                    check_ctrl(tmds.green, TMDS_CTRL_00, $sformatf("green (%0d,%0d)", h, v));
                    check_ctrl(tmds.blue, ctrl_code({f.vsync, f.hsync}),
                               $sformatf("blue (%0d,%0d)", h, v));
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_pixel);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: pixel %0d, control %0d, handshake %0d, frame_start %0d",
                 pix_errs, ctrl_errs, ack_errs, fs_errs);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the display path testbench with verilator, runs it, checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_hdmi_top -f src.f -o tb_hdmi_top \
    && ./obj_dir/tb_hdmi_top > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- src.f
+incdir+dv
verilog/video_pkg.sv
verilog/video_timing_gen.sv
verilog/pixel_write_port.sv
verilog/frame_buffer_ram.sv
verilog/upscale_fetch.sv
verilog/tmds_encoder.sv
verilog/hdmi_top.sv
dv/tb_hdmi_top.sv

//--- verilog/frame_buffer_ram.sv
`timescale 1ns/1ns
`default_nettype none

module frame_buffer_ram import video_pkg::*; #(
    parameter int DEPTH  = DEF_SRC_W * DEF_SRC_H,
    parameter int ADDR_W = $clog2(DEF_SRC_W * DEF_SRC_H)
) (
    input  wire               clk_pixel,
    input  wire               we,
    input  wire  [ADDR_W-1:0] waddr,
    input  wire rgb565_t      wdata,
    input  wire  [ADDR_W-1:0] raddr,
    output rgb565_t           rd_data
);

    rgb565_t mem [DEPTH]; // one 5:6:5 pixel per word

    // read-first, a same-address write shows up on the next read
    always_ff @(posedge clk_pixel) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rd_data <= mem[raddr]; // registered read port
    end

endmodule

`default_nettype wire

//--- verilog/hdmi_top.sv
`timescale 1ns/1ns
`default_nettype none

module hdmi_top import video_pkg::*; #(
    parameter int SRC_W        = DEF_SRC_W,
    parameter int SRC_H        = DEF_SRC_H,
    parameter int ZOOM_SHIFT   = DEF_ZOOM_SHIFT,
    parameter int H_ACTIVE     = DEF_H_ACTIVE,
    parameter int H_TOTAL      = DEF_H_TOTAL,
    parameter int H_SYNC_START = DEF_H_SYNC_START,
    parameter int H_SYNC_LEN   = DEF_H_SYNC_LEN,
    parameter int V_ACTIVE     = DEF_V_ACTIVE,
    parameter int V_TOTAL      = DEF_V_TOTAL,
    parameter int V_SYNC_START = DEF_V_SYNC_START,
    parameter int V_SYNC_LEN   = DEF_V_SYNC_LEN
) (
    input  wire          clk_pixel,
    input  wire          arst_n,
    input  wire          wr_req,
    input  wire pix_wr_t wr,
    output logic         wr_ack,
    output tmds_bus_t    tmds,
    output logic         frame_start
);

    localparam int DEPTH  = SRC_W * SRC_H;   // one word per source pixel
    localparam int ADDR_W = $clog2(DEPTH);

    logic [COORD_W-1:0] h_count;
    logic [COORD_W-1:0] v_count;
    vid_flags_t         flags;
    logic               scan_start;     // frame start at the counters
    logic               mem_we;
    logic [ADDR_W-1:0]  mem_addr;
    rgb565_t            mem_data;
    logic [ADDR_W-1:0]  rd_addr;
    rgb565_t            rd_data;
    rgb888_t            pix;
    vid_flags_t         pix_flags;
    tmds_word_t         tmds_red;
    tmds_word_t         tmds_green;
    tmds_word_t         tmds_blue;

    video_timing_gen #(
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
        .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
        .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
        .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
    ) u_timing (
        .clk_pixel(clk_pixel), .arst_n(arst_n),
        .h_count(h_count), .v_count(v_count),
        .flags(flags), .frame_start(scan_start)
    );

    pixel_write_port #(.SRC_W(SRC_W), .SRC_H(SRC_H), .ADDR_W(ADDR_W)) u_wr_port (
        .clk_pixel(clk_pixel), .arst_n(arst_n),
        .wr_req(wr_req), .wr(wr), .wr_ack(wr_ack),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_data(mem_data)
    );

    frame_buffer_ram #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) u_fb (
        .clk_pixel(clk_pixel),
        .we(mem_we), .waddr(mem_addr), .wdata(mem_data),
        .raddr(rd_addr), .rd_data(rd_data)
    );

    upscale_fetch #(
        .SRC_W(SRC_W), .SRC_H(SRC_H), .ZOOM_SHIFT(ZOOM_SHIFT), .ADDR_W(ADDR_W)
    ) u_fetch (
        .clk_pixel(clk_pixel), .arst_n(arst_n),
        .h_count(h_count), .v_count(v_count),
        .flags(flags), .frame_start(scan_start),
        .rd_data(rd_data), .rd_addr(rd_addr),
        .pix(pix), .pix_flags(pix_flags), .frame_start_out(frame_start)
    );

    // red and green idle on control code 00
    tmds_encoder u_enc_red (
        .clk_pixel(clk_pixel), .arst_n(arst_n), .data(pix.red),
        .ctrl(2'b00), .active(pix_flags.active), .tmds(tmds_red)
    );
    tmds_encoder u_enc_green (
        .clk_pixel(clk_pixel), .arst_n(arst_n), .data(pix.green),
        .ctrl(2'b00), .active(pix_flags.active), .tmds(tmds_green)
    );
    tmds_encoder u_enc_blue (   // c0 is hsync, c1 is vsync
        .clk_pixel(clk_pixel), .arst_n(arst_n), .data(pix.blue),
        .ctrl({pix_flags.vsync, pix_flags.hsync}), .active(pix_flags.active),
        .tmds(tmds_blue)
    );

    assign tmds = {tmds_blue, tmds_green, tmds_red};

endmodule

`default_nettype wire

//--- verilog/pixel_write_port.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_write_port import video_pkg::*; #(
    parameter int SRC_W  = DEF_SRC_W,
    parameter int SRC_H  = DEF_SRC_H,
    parameter int ADDR_W = $clog2(DEF_SRC_W * DEF_SRC_H)
) (
    input  wire               clk_pixel,
    input  wire               arst_n,
    input  wire               wr_req,
    input  wire pix_wr_t      wr,
    output logic              wr_ack,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output rgb565_t           mem_data
);

    wr_state_t state;
    logic      in_range; // request lands inside the source frame
    logic      take;     // new request accepted this cycle

    assign in_range = (wr.col < SRC_W) && (wr.row < SRC_H);
    assign take     = (state == WR_IDLE) && wr_req;

    // ack is a pure state decode, high for the whole release phase
    assign wr_ack = (state == WR_RELEASE);

    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            state  <= WR_IDLE;
            mem_we <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_req) begin
                        state  <= WR_ACK;
                        mem_we <= in_range; // out of range still gets acked
                    end
                end
                WR_ACK: begin
                    state  <= WR_RELEASE; // write lands on this edge
                    mem_we <= 1'b0;
                end
                WR_RELEASE: begin
                    if (!wr_req) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state  <= WR_IDLE;
                    mem_we <= 1'b0;
                end
            endcase
        end
    end

    // address and data captured with the request, row-major layout
    always_ff @(posedge clk_pixel) begin
        if (take) begin
            mem_addr <= ADDR_W'(wr.row * SRC_W + wr.col);
            mem_data <= wr.pixel;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tmds_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module tmds_encoder import video_pkg::*; (
    input  wire        clk_pixel,
    input  wire        arst_n,
    input  wire  [7:0] data,
    input  wire  [1:0] ctrl,   // {c1, c0}
    input  wire        active, // video period when high
    output tmds_word_t tmds
);

    logic [3:0]        ones_d;    // ones in the input byte
    logic [3:0]        ones_q;    // ones in q_m[7:0]
    logic [8:0]        q_m;       // transition minimised word, bit 8 marks xor
    logic signed [5:0] bal;       // ones minus zeros of q_m[7:0]
    logic signed [5:0] disp;      // running disparity
    logic signed [5:0] disp_next;
    tmds_word_t        word;
    tmds_word_t        ctrl_word;
    logic              started;   // first video data seen since reset

    // stage 1 of the dvi algorithm, pick xor or xnor chain
    always_comb begin
        ones_d = 4'($countones(data));
        q_m[0] = data[0];
        if (ones_d > 4'd4 || (ones_d == 4'd4 && !data[0])) begin
            for (int i = 1; i < 8; i++) begin
                q_m[i] = ~(q_m[i-1] ^ data[i]);
            end
            q_m[8] = 1'b0;
        end else begin
            for (int i = 1; i < 8; i++) begin
                q_m[i] = q_m[i-1] ^ data[i];
            end
            q_m[8] = 1'b1;
        end
        ones_q = 4'($countones(q_m[7:0]));
        bal    = $signed({1'b0, ones_q, 1'b0}) - 6'sd8;
    end

    // stage 2, dc balance against the running count
    always_comb begin
        if (disp == 0 || bal == 0) begin
            word      = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp + bal : disp - bal;
        end else if ((disp > 0 && bal > 0) || (disp < 0 && bal < 0)) begin
            word      = {1'b1, q_m[8], ~q_m[7:0]}; // invert to pull back
            disp_next = disp - bal + (q_m[8] ? 6'sd2 : 6'sd0);
        end else begin
            word      = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp + bal - (q_m[8] ? 6'sd0 : 6'sd2);
        end
    end

    always_comb begin
        case (ctrl)
            2'b00:   ctrl_word = TMDS_CTRL_00;
            2'b01:   ctrl_word = TMDS_CTRL_01;
            2'b10:   ctrl_word = TMDS_CTRL_10;
            default: ctrl_word = TMDS_CTRL_11;
        endcase
    end

    // output stays zero until the pipeline delivers its first active pixel
    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            tmds    <= '0;
            disp    <= '0;
            started <= 1'b0;
        end else if (active) begin
            tmds    <= word;
            disp    <= disp_next;
            started <= 1'b1;
        end else begin
            tmds <= started ? ctrl_word : '0;
            disp <= '0; // blanking restarts the balance
        end
    end

endmodule

`default_nettype wire

//--- verilog/upscale_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module upscale_fetch import video_pkg::*; #(
    parameter int SRC_W      = DEF_SRC_W,
    parameter int SRC_H      = DEF_SRC_H,
    parameter int ZOOM_SHIFT = DEF_ZOOM_SHIFT,
    parameter int ADDR_W     = $clog2(DEF_SRC_W * DEF_SRC_H)
) (
    input  wire                clk_pixel,
    input  wire                arst_n,
    input  wire  [COORD_W-1:0] h_count,
    input  wire  [COORD_W-1:0] v_count,
    input  wire vid_flags_t    flags,
    input  wire                frame_start,
    input  wire rgb565_t       rd_data,
    output logic [ADDR_W-1:0]  rd_addr,
    output rgb888_t            pix,
    output vid_flags_t         pix_flags,
    output logic               frame_start_out
);

    // 5:6:5 to 8:8:8, colour in the msbs
    function automatic rgb888_t expand(input rgb565_t p);
        rgb888_t c;
        c.red   = {p.red, 3'b000};
        c.green = {p.green, 2'b00};
        c.blue  = {p.blue, 3'b000};
        return c;
    endfunction

    logic [COORD_W-1:0] src_col;
    logic [COORD_W-1:0] src_row;
    logic               in_range_now;
    logic               in_range_d1;  // stage 1, address registered
    logic               in_range_d2;  // stage 2, ram data valid
    vid_flags_t         flags_d1;
    vid_flags_t         flags_d2;
    logic [3:0]         fs_pipe;      // three fetch stages plus the encoder register

    assign src_col      = h_count >> ZOOM_SHIFT;
    assign src_row      = v_count >> ZOOM_SHIFT;
    assign in_range_now = (src_col < SRC_W) && (src_row < SRC_H);

    // out of range reads are parked at 0 to stay inside the array
    always_ff @(posedge clk_pixel) begin
        rd_addr <= in_range_now ? ADDR_W'(src_row * SRC_W + src_col) : '0;
        pix     <= in_range_d2 ? expand(rd_data) : '0; // black outside the source
    end

    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            in_range_d1 <= 1'b0;
            in_range_d2 <= 1'b0;
            flags_d1    <= '0;
            flags_d2    <= '0;
            pix_flags   <= '0;
            fs_pipe     <= '0;
        end else begin
            in_range_d1 <= in_range_now;
            in_range_d2 <= in_range_d1;
            flags_d1    <= flags;
            flags_d2    <= flags_d1;
            pix_flags   <= flags_d2; // lines up with pix
            fs_pipe     <= {fs_pipe[2:0], frame_start};
        end
    end

    // one stage later than pix, matches the first encoded word
    assign frame_start_out = fs_pipe[3];

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // display counter width, 11 bits covers up to 2047 per line
    localparam int COORD_W = 11;

    // 4x zoom between source buffer and display
    localparam int DEF_ZOOM_SHIFT = 2;

    // source frame buffer size
    localparam int DEF_SRC_W = 320;
    localparam int DEF_SRC_H = 180;

    // 720p raster, positive sync polarity
    localparam int DEF_H_ACTIVE     = 1280;
    localparam int DEF_H_TOTAL      = 1650;
    localparam int DEF_H_SYNC_START = 1390; // after 110 px front porch
    localparam int DEF_H_SYNC_LEN   = 40;
    localparam int DEF_V_ACTIVE     = 720;
    localparam int DEF_V_TOTAL      = 750;
    localparam int DEF_V_SYNC_START = 725;  // after 5 line front porch
    localparam int DEF_V_SYNC_LEN   = 5;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // 5:6:5 value sits in the top bits, low bits are zero
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active; // inside the visible area
    } vid_flags_t;

    // one pixel write, col and row in source coordinates
    typedef struct packed {
        logic [8:0] col;
        logic [7:0] row;
        rgb565_t    pixel;
    } pix_wr_t;

    typedef logic [9:0] tmds_word_t;

    typedef struct packed {
        tmds_word_t blue;  // channel 0, carries sync in blanking
        tmds_word_t green;
        tmds_word_t red;
    } tmds_bus_t;

    typedef enum logic [1:0] {
        WR_IDLE,    // waiting for a request
        WR_ACK,     // memory write in flight
        WR_RELEASE  // ack held until req drops
    } wr_state_t;

    // control period symbols, index is {c1, c0}
    localparam tmds_word_t TMDS_CTRL_00 = 10'b1101010100;
    localparam tmds_word_t TMDS_CTRL_01 = 10'b0010101011;
    localparam tmds_word_t TMDS_CTRL_10 = 10'b0101010100;
    localparam tmds_word_t TMDS_CTRL_11 = 10'b1010101011;

endpackage

`default_nettype wire

//--- verilog/video_timing_gen.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing_gen import video_pkg::*; #(
    parameter int H_ACTIVE     = DEF_H_ACTIVE,
    parameter int H_TOTAL      = DEF_H_TOTAL,
    parameter int H_SYNC_START = DEF_H_SYNC_START,
    parameter int H_SYNC_LEN   = DEF_H_SYNC_LEN,
    parameter int V_ACTIVE     = DEF_V_ACTIVE,
    parameter int V_TOTAL      = DEF_V_TOTAL,
    parameter int V_SYNC_START = DEF_V_SYNC_START,
    parameter int V_SYNC_LEN   = DEF_V_SYNC_LEN
) (
    input  wire                clk_pixel,
    input  wire                arst_n,
    output logic [COORD_W-1:0] h_count,
    output logic [COORD_W-1:0] v_count,
    output vid_flags_t         flags,
    output logic               frame_start
);

    // flags that belong to a raster position
    function automatic vid_flags_t flags_at(input logic [COORD_W-1:0] h,
                                            input logic [COORD_W-1:0] v);
        vid_flags_t f;
        f.hsync  = (h >= H_SYNC_START) && (h < H_SYNC_START + H_SYNC_LEN);
        f.vsync  = (v >= V_SYNC_START) && (v < V_SYNC_START + V_SYNC_LEN);
        f.active = (h < H_ACTIVE) && (v < V_ACTIVE);
        return f;
    endfunction

    // reset parks the scan at the origin
    localparam vid_flags_t ORIGIN_FLAGS = flags_at('0, '0);

    logic [COORD_W-1:0] h_next;
    logic [COORD_W-1:0] v_next;

    always_comb begin
        h_next = h_count + 1'b1;
        v_next = v_count;
        if (h_count == COORD_W'(H_TOTAL - 1)) begin // end of line
            h_next = '0;
            v_next = (v_count == COORD_W'(V_TOTAL - 1)) ? '0 : v_count + 1'b1;
        end
    end

    // flags are computed for the next position so they line up with the counts
    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            h_count     <= '0;
            v_count     <= '0;
            flags       <= ORIGIN_FLAGS;
            frame_start <= 1'b1; // origin is shown straight out of reset
        end else begin
            h_count     <= h_next;
            v_count     <= v_next;
            flags       <= flags_at(h_next, v_next);
            frame_start <= (h_next == '0) && (v_next == '0);
        end
    end

endmodule

`default_nettype wire
